/* all.f */
fetch_pkg.sv
fe_phase_if.sv
fetch_req_ctrl.sv
fetch_resp_ctrl.sv
instr_fifo.sv
fetch_stage.sv
tb_clk_gen.sv
tb_fetch_stage.sv

/* fe_phase_if.sv */
/*
 * FE0 to FE1 phase link
 * Carries the address-phase state forward and the held
 * redirect of the data phase back to the address phase
 */
`timescale 1ns/1ps

interface fe_phase_if;

    fetch_pkg::waddr_t fe0_add;        // Address in FE0
    logic              fe0_utd;        // FE0 holds a live request
    logic              fe0_pmavn;      // FE0 address outside PMA region

    logic              fe1_utd;        // FE1 awaits live data
    logic              held_redirect;  // FE1 keeps a redirect target
    fetch_pkg::waddr_t held_add;       // The redirect target itself

    // Address-phase side
    modport req (
        output fe0_add, fe0_utd, fe0_pmavn,
        input  fe1_utd, held_redirect, held_add
    );

    // Data-phase side
    modport resp (
        input  fe0_add, fe0_utd, fe0_pmavn,
        output fe1_utd, held_redirect, held_add
    );

endinterface

/* fetch_pkg.sv */
/*
 * Fetch stage shared definitions
 * Word address and instruction types, fetch status codes,
 * the instruction fetch buffer entry and the bus transfer codes
 */
package fetch_pkg;

    // Word fetch address, the byte offset bits are implied zero
    typedef logic [29:0] waddr_t;

    typedef logic [31:0] instr_t;

    // Status carried with every fetched word to decode
    typedef enum logic [1:0] {
        FETCH_VALID = 2'b00,  // Normal fetch
        FETCH_BSERR = 2'b01,  // Bus error response
        FETCH_PMAVN = 2'b10   // Outside PMA region, no transfer made
    } fetch_status_t;

    // One slot of the instruction fetch buffer
    typedef struct packed {
        instr_t        instr;   // Fetched word
        fetch_status_t status;  // How it was obtained
    } ifb_entry_t;

    // AHB transfer type codes
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    // First fetch word address after reset (byte address 0x100)
    localparam waddr_t RESET_VECTOR = 30'h0000_0040;

endpackage

/* fetch_req_ctrl.sv */
/*
 * Fetch address phase controller (FE0)
 * Picks the next fetch address, checks it against the PMA region
 * and drives the AHB address phase
 */
`timescale 1ns/1ps

module fetch_req_ctrl #(
    parameter fetch_pkg::waddr_t PMA_BASE  = 30'h0000_0000,
    parameter fetch_pkg::waddr_t PMA_LIMIT = 30'h0000_0FFF
) (
    input  logic              s_clk_i,
    input  logic              rst_n_i,

    input  logic              flush_i,        // Redirect from a later stage
    input  fetch_pkg::waddr_t toc_add_i,      // Redirect target
    input  logic              hready_i,       // Bus ready
    input  logic              can_reserve_i,  // Buffer has room for one more request

    fe_phase_if.req           phase,

    output logic [31:0]       haddr_o,
    output logic [1:0]        htrans_o
);

    fetch_pkg::waddr_t fe0_add_q;  // FE0 fetch address
    logic              fe0_utd_q;  // FE0 request is live
    logic              fe0_hold;   // Address phase not yet accepted
    logic              pma_vn;     // FE0 address out of region

    /*
     * An address phase that is live and sees hready low has not been
     * taken by the bus, so FE0 must not move
     */
    assign fe0_hold = ~hready_i & fe0_utd_q;

    // Single region check on the word address
    assign pma_vn = (fe0_add_q < PMA_BASE) | (fe0_add_q > PMA_LIMIT);

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            fe0_add_q <= fetch_pkg::RESET_VECTOR;
            fe0_utd_q <= 1'b0;
        end else if (fe0_hold) begin
            fe0_add_q <= fe0_add_q;  // Keep haddr and htrans stable
            fe0_utd_q <= 1'b1;
        end else if (flush_i) begin
            // Buffer is emptied at this edge, so room is certain
            fe0_add_q <= toc_add_i;
            fe0_utd_q <= 1'b1;
        end else if (phase.held_redirect) begin
            // Target parked in FE1 during the stall, buffer still empty
            fe0_add_q <= phase.held_add;
            fe0_utd_q <= 1'b1;
        end else if (fe0_utd_q) begin
            fe0_add_q <= fe0_add_q + 1'b1;  // Sequential word fetch
            fe0_utd_q <= can_reserve_i;
        end else begin
            // Waiting for buffer room, address already points ahead
            fe0_add_q <= fe0_add_q;
            fe0_utd_q <= can_reserve_i;
        end
    end

    // State seen by the data phase
    assign phase.fe0_add   = fe0_add_q;
    assign phase.fe0_utd   = fe0_utd_q;
    assign phase.fe0_pmavn = pma_vn;

    // Bus address phase
    assign haddr_o  = {fe0_add_q, 2'b00};  // Word aligned
    assign htrans_o = (fe0_utd_q & ~pma_vn) ? fetch_pkg::HTRANS_NONSEQ  // No transfer on violation
                                            : fetch_pkg::HTRANS_IDLE;

endmodule

/* fetch_resp_ctrl.sv */
/*
 * Fetch data phase controller (FE1)
 * Tracks the request in its data phase, parks a redirect that
 * arrives while FE0 is stalled, and builds the buffer entry
 */
`timescale 1ns/1ps

module fetch_resp_ctrl (
    input  logic                  s_clk_i,
    input  logic                  rst_n_i,

    input  logic                  flush_i,    // Redirect from a later stage
    input  fetch_pkg::waddr_t     toc_add_i,  // Redirect target
    input  logic                  hready_i,   // Bus ready, ends the data phase
    input  logic [31:0]           hrdata_i,   // Bus read data
    input  logic                  hresp_i,    // Bus error response

    fe_phase_if.resp              phase,

    output logic                  push_o,     // Write entry into the buffer
    output fetch_pkg::ifb_entry_t entry_o
);

    fetch_pkg::waddr_t fe1_add_q;    // Held redirect target or request address
    logic              fe1_utd_q;    // Data of FE1 is wanted
    logic              fe1_held_q;   // FE1 parks a redirect, no live fetch
    logic              fe1_pmavn_q;  // Request made no transfer
    logic              park;         // Redirect must wait in FE1

    // FE0 cannot take the target while its address phase is stalled
    assign park = flush_i & ~hready_i & phase.fe0_utd;

    // Control part of FE1
    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            fe1_utd_q  <= 1'b0;
            fe1_held_q <= 1'b0;
        end else if (park) begin
            fe1_utd_q  <= 1'b0;  // Any data in flight is stale now
            fe1_held_q <= 1'b1;
        end else if (flush_i | (hready_i & fe1_held_q)) begin
            // Flush, or FE0 took the parked target
            fe1_utd_q  <= 1'b0;
            fe1_held_q <= 1'b0;
        end else if (hready_i) begin
            fe1_utd_q  <= phase.fe0_utd;  // Address phase accepted
            fe1_held_q <= 1'b0;
        end
    end

    // Payload part of FE1
    always_ff @(posedge s_clk_i) begin
        if (park) begin
            fe1_add_q   <= toc_add_i;
            fe1_pmavn_q <= 1'b0;
        end else if (hready_i) begin
            fe1_add_q   <= phase.fe0_add;
            fe1_pmavn_q <= phase.fe0_pmavn;
        end
    end

    assign phase.fe1_utd       = fe1_utd_q;
    assign phase.held_redirect = fe1_held_q;
    assign phase.held_add      = fe1_add_q;

    // Data phase ends on hready with a live FE1
    assign push_o = fe1_utd_q & hready_i;

    always_comb begin
        if (fe1_pmavn_q) begin
            entry_o.instr  = '0;  // No bus data behind this entry
            entry_o.status = fetch_pkg::FETCH_PMAVN;
        end else if (hresp_i) begin
            entry_o.instr  = hrdata_i;
            entry_o.status = fetch_pkg::FETCH_BSERR;
        end else begin
            entry_o.instr  = hrdata_i;
            entry_o.status = fetch_pkg::FETCH_VALID;
        end
    end

endmodule

/* fetch_stage.sv */
/*
 * Instruction fetch stage top
 * Two-phase AHB fetch (FE0 address, FE1 data) feeding the
 * instruction fetch buffer read by decode
 */
`timescale 1ns/1ps

module fetch_stage #(
    parameter int                IFB_DEPTH = 4,             // At least 3
    parameter fetch_pkg::waddr_t PMA_BASE  = 30'h0000_0000,
    parameter fetch_pkg::waddr_t PMA_LIMIT = 30'h0000_0FFF
) (
    input  logic                     s_clk_i,
    input  logic                     rst_n_i,

    // Redirect from a later stage
    input  logic                     flush_i,
    input  fetch_pkg::waddr_t        toc_add_i,

    // AHB instruction bus
    output logic [31:0]              haddr_o,
    output logic [1:0]               htrans_o,
    input  logic [31:0]              hrdata_i,
    input  logic                     hready_i,
    input  logic                     hresp_i,

    // Decode side
    output logic                     instr_valid_o,
    output fetch_pkg::instr_t        instr_o,
    output fetch_pkg::fetch_status_t instr_status_o,
    input  logic                     stall_i
);

    fe_phase_if phase ();

    logic                  ifb_push;
    fetch_pkg::ifb_entry_t ifb_wentry;
    fetch_pkg::ifb_entry_t ifb_rentry;
    logic                  can_reserve;
    logic [1:0]            in_flight;  // Live FE0 plus live FE1

    assign in_flight = {phase.fe0_utd & phase.fe1_utd, phase.fe0_utd ^ phase.fe1_utd};

    // Address phase
    fetch_req_ctrl #(
        .PMA_BASE  (PMA_BASE),
        .PMA_LIMIT (PMA_LIMIT)
    ) u_req (
        .s_clk_i       (s_clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .toc_add_i     (toc_add_i),
        .hready_i      (hready_i),
        .can_reserve_i (can_reserve),
        .phase         (phase.req),
        .haddr_o       (haddr_o),
        .htrans_o      (htrans_o)
    );

    // Data phase
    fetch_resp_ctrl u_resp (
        .s_clk_i   (s_clk_i),
        .rst_n_i   (rst_n_i),
        .flush_i   (flush_i),
        .toc_add_i (toc_add_i),
        .hready_i  (hready_i),
        .hrdata_i  (hrdata_i),
        .hresp_i   (hresp_i),
        .phase     (phase.resp),
        .push_o    (ifb_push),
        .entry_o   (ifb_wentry)
    );

    // Fetch buffer, decode pops whenever it is not stalled
    instr_fifo #(
        .IFB_DEPTH (IFB_DEPTH)
    ) u_ifb (
        .s_clk_i       (s_clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .push_i        (ifb_push),
        .entry_i       (ifb_wentry),
        .pop_i         (~stall_i),
        .in_flight_i   (in_flight),
        .entry_o       (ifb_rentry),
        .valid_o       (instr_valid_o),
        .can_reserve_o (can_reserve)
    );

    assign instr_o        = ifb_rentry.instr;
    assign instr_status_o = ifb_rentry.status;

endmodule

/* instr_fifo.sv */
/*
 * Instruction fetch buffer
 * Circular buffer between fetch and decode with flush,
 * occupancy count and the room check for new requests
 */
`timescale 1ns/1ps

module instr_fifo #(
    parameter int IFB_DEPTH = 4
) (
    input  logic                  s_clk_i,
    input  logic                  rst_n_i,

    input  logic                  flush_i,        // Drop all entries
    input  logic                  push_i,
    input  fetch_pkg::ifb_entry_t entry_i,
    input  logic                  pop_i,          // Decode takes the head
    input  logic [1:0]            in_flight_i,    // Requests still to deliver data

    output fetch_pkg::ifb_entry_t entry_o,
    output logic                  valid_o,
    output logic                  can_reserve_o   // Room for one more request
);

    localparam int PTR_W = $clog2(IFB_DEPTH);
    localparam int CNT_W = $clog2(IFB_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(IFB_DEPTH - 1);

    fetch_pkg::ifb_entry_t mem [IFB_DEPTH];  // Entry storage

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;    // Occupied entries
    logic [CNT_W-1:0] free_cnt;
    logic             do_pop;

    assign do_pop = pop_i & valid_o;  // Popping an empty buffer is ignored

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Both or neither
            endcase
        end
    end

    // Storage write, room guaranteed by the reservation
    always_ff @(posedge s_clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= entry_i;
        end
    end

    assign entry_o = mem[rd_ptr_q];
    assign valid_o = (count_q != '0);

    /*
     * A new request may start only if every request already in flight,
     * and the new one, will find a free entry on arrival
     */
    assign free_cnt      = CNT_W'(IFB_DEPTH) - count_q;
    assign can_reserve_o = free_cnt > CNT_W'(in_flight_i);

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_fetch_stage -o sim_fetch
output="$(./obj_dir/sim_fetch)"
echo "$output"

if grep -qx "Done: no errors" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* tb_clk_gen.sv */
/*
 * Testbench clock and reset generator
 * Free running clock and an active low reset held for a few cycles
 */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 8,  // Clock period
    parameter int RST_CYCLES = 4   // Rising edges seen with reset low
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release 1 ns after an edge, like every other driven input
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

/* tb_fetch_stage.sv */
/*
 * Fetch stage testbench
 * AHB memory model with random wait states, random decode stalls,
 * a table of tests with flushes, and a reference queue of consumed entries
 */
`timescale 1ns/1ps

module tb_fetch_stage;

    localparam int                CLK_PERIOD = 8;
    localparam int                IFB_DEPTH  = 4;
    localparam fetch_pkg::waddr_t PMA_BASE   = 30'h0000_0010;
    localparam fetch_pkg::waddr_t PMA_LIMIT  = 30'h0000_03FF;
    localparam fetch_pkg::waddr_t ERR_LO     = 30'h0000_0120;  // Bus error window
    localparam fetch_pkg::waddr_t ERR_HI     = 30'h0000_0127;
    localparam logic [31:0]       DATA_PAT   = 32'hA5C3_0F96;  // Memory fill pattern
    localparam int                NUM_TESTS  = 8;

    logic                     clk;
    logic                     rst_n;
    logic                     flush;
    fetch_pkg::waddr_t        toc_add;
    logic [31:0]              haddr;
    logic [1:0]               htrans;
    logic [31:0]              hrdata;
    logic                     hready;
    logic                     hresp;
    logic                     instr_valid;
    fetch_pkg::instr_t        instr;
    fetch_pkg::fetch_status_t instr_status;
    logic                     stall;

    // Test table with one row per test
    string             name_tab   [NUM_TESTS];
    int                cycles_tab [NUM_TESTS];
    int                stall_tab  [NUM_TESTS];  // Decode stall in percent
    int                hlow_tab   [NUM_TESTS];  // hready low in percent
    int                flush_tab  [NUM_TESTS];  // Flush cycle or -1 for none
    fetch_pkg::waddr_t tgt_tab    [NUM_TESTS];
    int                hold_tab   [NUM_TESTS];  // Forced hready low cycles from the flush

    fetch_pkg::waddr_t ref_q [$];   // Expected addresses of the next consumed entries
    fetch_pkg::waddr_t ref_next;

    logic              dph_valid;      // Bus data phase in progress
    fetch_pkg::waddr_t dph_add;
    logic              nxt_dph_valid;  // Data phase for the coming cycle
    fetch_pkg::waddr_t nxt_dph_add;
    logic [31:0]       prev_haddr;
    logic [1:0]        prev_htrans;
    logic              prev_hready;
    logic              flush_prev;
    logic              first_cycle;
    int                hold_left;
    int                seed;
    int                errors;
    int                checks;
    int                consumed;
    int                test_consumed;  // Entries taken since test start or its flush
    string             cur_name;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(4)) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fetch_stage #(
        .IFB_DEPTH (IFB_DEPTH),
        .PMA_BASE  (PMA_BASE),
        .PMA_LIMIT (PMA_LIMIT)
    ) DUT (
        .s_clk_i        (clk),
        .rst_n_i        (rst_n),
        .flush_i        (flush),
        .toc_add_i      (toc_add),
        .haddr_o        (haddr),
        .htrans_o       (htrans),
        .hrdata_i       (hrdata),
        .hready_i       (hready),
        .hresp_i        (hresp),
        .instr_valid_o  (instr_valid),
        .instr_o        (instr),
        .instr_status_o (instr_status),
        .stall_i        (stall)
    );

    task automatic set_row(input int idx, input string name, input int cycles,
                           input int stall_pct, input int hlow_pct, input int flush_at,
                           input fetch_pkg::waddr_t tgt, input int hold);
        name_tab[idx]   = name;
        cycles_tab[idx] = cycles;
        stall_tab[idx]  = stall_pct;
        hlow_tab[idx]   = hlow_pct;
        flush_tab[idx]  = flush_at;
        tgt_tab[idx]    = tgt;
        hold_tab[idx]   = hold;
    endtask

    function automatic int total_cycles();
        int sum;
        sum = 0;
        for (int t = 0; t < NUM_TESTS; t++) sum += cycles_tab[t];
        return sum;
    endfunction

    function automatic int rand_pct();
        return int'($unsigned($random(seed)) % 100);
    endfunction

    // Memory content from the whole word address
    function automatic logic [31:0] bus_word(input fetch_pkg::waddr_t a);
        return {2'b00, a} ^ DATA_PAT;
    endfunction

    function automatic logic in_err_window(input fetch_pkg::waddr_t a);
        return (a >= ERR_LO) && (a <= ERR_HI);
    endfunction

    // Status decode should see for a word address
    function automatic fetch_pkg::fetch_status_t expect_status(input fetch_pkg::waddr_t a);
        if ((a < PMA_BASE) || (a > PMA_LIMIT)) return fetch_pkg::FETCH_PMAVN;
        if (in_err_window(a)) return fetch_pkg::FETCH_BSERR;
        return fetch_pkg::FETCH_VALID;
    endfunction

    task automatic restart_ref(input fetch_pkg::waddr_t start);
        ref_q.delete();
        ref_next = start;
    endtask

    // Next address in program order from a sequentially topped up queue
    task automatic next_expected(output fetch_pkg::waddr_t a);
        while (ref_q.size() < IFB_DEPTH) begin
            ref_q.push_back(ref_next);
            ref_next = ref_next + 30'd1;
        end
        a = ref_q.pop_front();
    endtask

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", cur_name, what, expected, actual);
        end
    endtask

    // A test must deliver entries after its start or its redirect
    task automatic check_progress();
        checks++;
        assert (test_consumed > 0) else begin
            errors++;
            $display("Fail %s progress: expected entries consumed, actual %0d",
                     cur_name, test_consumed);
        end
    endtask

    // Inputs for one cycle applied 1 ns after the edge
    task automatic drive_cycle(input int t, input int c);
        logic fl;
        fl        = (c == flush_tab[t]);
        dph_valid = nxt_dph_valid;
        dph_add   = nxt_dph_add;
        if (fl) hold_left = hold_tab[t];
        stall = (rand_pct() < stall_tab[t]);
        if (hold_left > 0) begin
            hready    = 1'b0;  // Keep FE0 stalled so the target must wait
            hold_left = hold_left - 1;
        end else begin
            hready = !(rand_pct() < hlow_tab[t]);
        end
        flush   = fl;
        toc_add = fl ? tgt_tab[t] : toc_add;
        hrdata  = dph_valid ? bus_word(dph_add) : 32'h0;
        hresp   = dph_valid && in_err_window(dph_add);
    endtask

    // Outputs are stable at the falling edge
    task automatic sample_cycle();
        fetch_pkg::waddr_t a;
        if (first_cycle) begin
            compare_value("first htrans", fetch_pkg::HTRANS_NONSEQ, htrans);
            compare_value("first haddr", {fetch_pkg::RESET_VECTOR, 2'b00}, haddr);
            first_cycle = 1'b0;
        end
        if (flush_prev) compare_value("valid after flush", 32'd0, instr_valid);
        if (htrans == fetch_pkg::HTRANS_NONSEQ) begin
            checks++;
            assert ((haddr[31:2] >= PMA_BASE) && (haddr[31:2] <= PMA_LIMIT)) else begin
                errors++;
                $display("Fail %s pma: expected address in %h..%h, actual %h",
                         cur_name, PMA_BASE, PMA_LIMIT, haddr[31:2]);
            end
        end
        // Address phase must not move during a wait state
        if (!prev_hready && (prev_htrans == fetch_pkg::HTRANS_NONSEQ)) begin
            compare_value("held haddr", prev_haddr, haddr);
            compare_value("held htrans", prev_htrans, htrans);
        end
        if (instr_valid && !stall) begin
            next_expected(a);
            compare_value("status", expect_status(a), instr_status);
            if (expect_status(a) != fetch_pkg::FETCH_PMAVN) begin
                compare_value("instr", bus_word(a), instr);
            end
            consumed++;
            test_consumed++;
        end
        if (flush) begin
            restart_ref(toc_add);  // Entries before the flush are gone
            test_consumed = 0;
        end
        flush_prev = flush;
        if (hready) begin
            nxt_dph_valid = (htrans == fetch_pkg::HTRANS_NONSEQ);
            nxt_dph_add   = haddr[31:2];
        end
        prev_haddr  = haddr;
        prev_htrans = htrans;
        prev_hready = hready;
    endtask

    initial begin
        flush         = 1'b0;
        toc_add       = '0;
        hrdata        = '0;
        hready        = 1'b1;
        hresp         = 1'b0;
        stall         = 1'b0;
        seed          = 13;
        errors        = 0;
        checks        = 0;
        consumed      = 0;
        test_consumed = 0;
        hold_left     = 0;
        nxt_dph_valid = 1'b0;
        nxt_dph_add   = '0;
        prev_haddr    = '0;
        prev_htrans   = fetch_pkg::HTRANS_IDLE;
        prev_hready   = 1'b1;
        flush_prev    = 1'b0;
        first_cycle   = 1'b1;

        //        name                cyc  stall hlow flush target        hold
        set_row(0, "reset_seq",        40,   0,   0,  -1, 30'h0,          0);
        set_row(1, "random_stall",    200,  40,  30,  -1, 30'h0,          0);
        set_row(2, "flush_seq",        60,  20,  20,  10, 30'h0000_0200,  0);
        set_row(3, "flush_hready_low", 60,  10,  20,  15, 30'h0000_0300,  3);
        set_row(4, "bus_error",        60,  20,  20,   0, 30'h0000_011C,  0);
        set_row(5, "pma_limit",        40,  10,  10,   0, 30'h0000_03FC,  0);  // Runs past the limit
        set_row(6, "pma_base",         40,  10,  10,   0, 30'h0000_000D,  0);  // Starts below the base
        set_row(7, "drain",            30,   0,   0,  -1, 30'h0,          0);

        @(posedge rst_n);
        cur_name = "reset";
        compare_value("htrans in reset", fetch_pkg::HTRANS_IDLE, htrans);
        compare_value("valid in reset", 32'd0, instr_valid);
        restart_ref(fetch_pkg::RESET_VECTOR);

        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_name      = name_tab[t];
            test_consumed = 0;
            for (int c = 0; c < cycles_tab[t]; c++) begin
                @(posedge clk);
                #1;
                drive_cycle(t, c);
                @(negedge clk);
                sample_cycle();
            end
            check_progress();
        end

        $display("Checks: %0d, entries consumed: %0d, errors: %0d", checks, consumed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Ends a run that stops making progress
    initial begin : watchdog
        int total;
        @(posedge rst_n);
        total = total_cycles();
        #(2 * total * CLK_PERIOD);
        $display("Timeout: the test table did not finish in time");
        $display("Checks: %0d, entries consumed: %0d, errors: %0d", checks, consumed, errors + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule
